// ==== all.f ====
hw/sparse_pkg.sv
hw/sparsemap_wr_if.sv
hw/sparsemap_loader.sv
hw/sparsemap_pingpong_buf.sv
hw/dat_chunk_comb_sparsemap.sv
hw/chunk_popcount_unit.sv
hw/sparse_chunk_top.sv
test/tb_sparse_chunk.sv

// ==== hw/chunk_popcount_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module chunk_popcount_unit (
	input  wire logic                                   clk_i,
	input  wire logic                                   rst_n_i,
	input  wire logic                                   q_valid_i,
	input  wire logic [sparse_pkg::PREFIX_SUM_SIZE-1:0] chunk_i,
	output logic      [sparse_pkg::PREFIX_SUM_SIZE-1:0] chunk_o,
	output logic      [sparse_pkg::CNT_W-1:0]           count_o,
	output logic                                        valid_o
);

	logic [sparse_pkg::CNT_W-1:0]           count_d;
	logic [sparse_pkg::PREFIX_SUM_SIZE-1:0] chunk_q;
	logic [sparse_pkg::CNT_W-1:0]           count_q;
	logic                                   valid_q;

	////////////////////////////////////////
	// Set-bit count
	////////////////////////////////////////

	// Non-zero count for the prefix sums
	always_comb begin
		count_d = '0;
		for (int i = 0; i < sparse_pkg::PREFIX_SUM_SIZE; i++) begin
			count_d = count_d + {{(sparse_pkg::CNT_W-1){1'b0}}, chunk_i[i]};
		end
	end

	// Payload capture on query
	always_ff @(posedge clk_i) begin
		if (q_valid_i) begin
			chunk_q <= chunk_i;
			count_q <= count_d;
		end
	end

	// Valid tracks the query one cycle late
	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			valid_q <= 1'b0;
		end else begin
			valid_q <= q_valid_i;
		end
	end

	assign chunk_o = chunk_q;
	assign count_o = count_q;
	assign valid_o = valid_q;

	// Count is bounded by the chunk width
	a_count_range: assert property (
		@(posedge clk_i) disable iff (!rst_n_i)
		valid_o |-> (count_o <= sparse_pkg::PREFIX_SUM_SIZE)
	);

endmodule

`default_nettype wire

// ==== hw/dat_chunk_comb_sparsemap.sv ====
`timescale 1ns/1ps
`default_nettype none

module dat_chunk_comb_sparsemap (
	input  wire logic                                                   rd_sel_i,
	input  wire logic [1:0][sparse_pkg::MEM_SIZE-1:0]                   rd_sparsemap_i,
	input  wire logic [sparse_pkg::COMPUTE_UNIT_NUM-1:0]
	                  [sparse_pkg::CHUNK_ADDR_W-1:0]                    rd_sparsemap_addr_i,
	output logic      [sparse_pkg::COMPUTE_UNIT_NUM-1:0]
	                  [sparse_pkg::PREFIX_SUM_SIZE-1:0]                 rd_sparsemap_o
);

	// Per-bank copy of every unit address
	logic [1:0][sparse_pkg::COMPUTE_UNIT_NUM-1:0][sparse_pkg::CHUNK_ADDR_W-1:0] bank_addr;
	// Per-bank chunk for every unit
	logic [1:0][sparse_pkg::COMPUTE_UNIT_NUM-1:0][sparse_pkg::PREFIX_SUM_SIZE-1:0] bank_chunk;

	// Steer addresses, idle bank sees zero
	always_comb begin
		for (int u = 0; u < sparse_pkg::COMPUTE_UNIT_NUM; u++) begin
			bank_addr[0][u] = rd_sel_i ? '0 : rd_sparsemap_addr_i[u];
			bank_addr[1][u] = rd_sel_i ? rd_sparsemap_addr_i[u] : '0;
		end
	end

	// Chunk mux per bank and unit
	always_comb begin
		for (int b = 0; b < 2; b++) begin
			for (int u = 0; u < sparse_pkg::COMPUTE_UNIT_NUM; u++) begin
				bank_chunk[b][u] = '0;
				for (int k = 0; k < sparse_pkg::CHUNK_NUM; k++) begin
					// chunk k = bits PREFIX_SUM_SIZE*k upward
					if (bank_addr[b][u] == k) begin
						bank_chunk[b][u] =
							rd_sparsemap_i[b][sparse_pkg::PREFIX_SUM_SIZE*k +: sparse_pkg::PREFIX_SUM_SIZE];
					end
				end
			end
		end
	end

	// Final pick from the readable bank
	always_comb begin
		for (int u = 0; u < sparse_pkg::COMPUTE_UNIT_NUM; u++) begin
			rd_sparsemap_o[u] = rd_sel_i ? bank_chunk[1][u] : bank_chunk[0][u];
		end
	end

endmodule

`default_nettype wire

// ==== hw/sparse_chunk_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module sparse_chunk_top (
	input  wire logic                         clk_i,
	input  wire logic                         rst_n_i,
	// Sparsemap load stream
	input  wire logic                         ld_valid_i,
	input  wire logic [sparse_pkg::LD_WORD_W-1:0] ld_data_i,
	// Per-unit chunk queries with unit j at bits CHUNK_ADDR_W*j
	input  wire logic                         q_valid_i,
	input  wire logic [sparse_pkg::COMPUTE_UNIT_NUM*sparse_pkg::CHUNK_ADDR_W-1:0] q_addr_i,
	output logic                              map_ready_o,
	output logic                              count_valid_o,
	output logic [sparse_pkg::COMPUTE_UNIT_NUM*sparse_pkg::PREFIX_SUM_SIZE-1:0] chunks_o,
	output logic [sparse_pkg::COMPUTE_UNIT_NUM*sparse_pkg::CNT_W-1:0]           counts_o
);

	logic [1:0][sparse_pkg::MEM_SIZE-1:0]                                          banks;
	logic                                                                          rd_sel;
	logic [sparse_pkg::COMPUTE_UNIT_NUM-1:0][sparse_pkg::CHUNK_ADDR_W-1:0]          unit_addr;
	logic [sparse_pkg::COMPUTE_UNIT_NUM-1:0][sparse_pkg::PREFIX_SUM_SIZE-1:0]       unit_chunk;
	logic [sparse_pkg::COMPUTE_UNIT_NUM-1:0][sparse_pkg::PREFIX_SUM_SIZE-1:0]       unit_chunk_q;
	logic [sparse_pkg::COMPUTE_UNIT_NUM-1:0][sparse_pkg::CNT_W-1:0]                 unit_count;
	logic [sparse_pkg::COMPUTE_UNIT_NUM-1:0]                                       unit_valid;

	sparsemap_wr_if wr_if ();

	////////////////////////////////////////
	// Producer and storage
	////////////////////////////////////////

	sparsemap_loader u_loader (
		.clk_i      (clk_i),
		.rst_n_i    (rst_n_i),
		.ld_valid_i (ld_valid_i),
		.ld_data_i  (ld_data_i),
		.wr         (wr_if.loader)
	);

	sparsemap_pingpong_buf u_buf (
		.clk_i       (clk_i),
		.rst_n_i     (rst_n_i),
		.wr          (wr_if.buffer),
		.bank_o      (banks),
		.rd_sel_o    (rd_sel),
		.map_ready_o (map_ready_o)
	);

	////////////////////////////////////////
	// Consumers
	////////////////////////////////////////

	// Flat query bus already matches the packed unit layout
	assign unit_addr = q_addr_i;

	dat_chunk_comb_sparsemap u_reader (
		.rd_sel_i            (rd_sel),
		.rd_sparsemap_i      (banks),
		.rd_sparsemap_addr_i (unit_addr),
		.rd_sparsemap_o      (unit_chunk)
	);

	for (genvar j = 0; j < sparse_pkg::COMPUTE_UNIT_NUM; j++) begin : g_unit
		chunk_popcount_unit u_pop (
			.clk_i     (clk_i),
			.rst_n_i   (rst_n_i),
			.q_valid_i (q_valid_i),
			.chunk_i   (unit_chunk[j]),
			.chunk_o   (unit_chunk_q[j]),
			.count_o   (unit_count[j]),
			.valid_o   (unit_valid[j])
		);
	end

	// Units run in lockstep so unit 0 speaks for all
	assign count_valid_o = unit_valid[0];
	assign chunks_o      = unit_chunk_q;
	assign counts_o      = unit_count;

endmodule

`default_nettype wire

// ==== hw/sparse_pkg.sv ====
`default_nettype none

package sparse_pkg;

	////////////////////////////////////////
	// Sparsemap geometry
	////////////////////////////////////////

	// Bits held by one bank
	localparam int MEM_SIZE = 64;
	// One chunk per prefix-sum step
	localparam int PREFIX_SUM_SIZE = 8;
	localparam int CHUNK_NUM = MEM_SIZE / PREFIX_SUM_SIZE;
	localparam int CHUNK_ADDR_W = $clog2(CHUNK_NUM);

	// Compute array width
	localparam int COMPUTE_UNIT_NUM = 4;

	////////////////////////////////////////
	// Load stream
	////////////////////////////////////////

	localparam int LD_WORD_W = 16;
	// Words needed to fill a bank
	localparam int LD_WORD_NUM = MEM_SIZE / LD_WORD_W;
	localparam int LD_ADDR_W = $clog2(LD_WORD_NUM);
	// Index of the word that completes a bank
	localparam logic [LD_ADDR_W-1:0] LD_ADDR_LAST = LD_ADDR_W'(LD_WORD_NUM - 1);

	// Popcount result, 0 up to PREFIX_SUM_SIZE inclusive
	localparam int CNT_W = $clog2(PREFIX_SUM_SIZE + 1);

endpackage

`default_nettype wire

// ==== hw/sparsemap_loader.sv ====
`timescale 1ns/1ps
`default_nettype none

module sparsemap_loader (
	input  wire logic                             clk_i,
	input  wire logic                             rst_n_i,
	input  wire logic                             ld_valid_i,
	input  wire logic [sparse_pkg::LD_WORD_W-1:0] ld_data_i,
	sparsemap_wr_if.loader                        wr
);

	// Word index inside the map being loaded
	logic [sparse_pkg::LD_ADDR_W-1:0] word_cnt_q;
	// Bank currently being filled
	logic                             wr_bank_q;
	logic                             last_word;

	assign last_word = (word_cnt_q == sparse_pkg::LD_ADDR_LAST);

	////////////////////////////////////////
	// Write presentation
	////////////////////////////////////////

	// Stream word goes straight to the buffer
	assign wr.wr_en   = ld_valid_i;
	assign wr.wr_bank = wr_bank_q;
	assign wr.wr_addr = word_cnt_q;
	assign wr.wr_data = ld_data_i;
	// Fourth word closes the bank
	assign wr.commit  = ld_valid_i & last_word;

	////////////////////////////////////////
	// Pointers
	////////////////////////////////////////

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			word_cnt_q <= '0;
			wr_bank_q  <= 1'b0;
		end else if (ld_valid_i) begin
			if (last_word) begin
				// Next map starts in the other bank
				word_cnt_q <= '0;
				wr_bank_q  <= ~wr_bank_q;
			end else begin
				word_cnt_q <= word_cnt_q + 1'b1;
			end
		end
	end

	// Commit only rides on a write of the last word
	a_commit_with_write: assert property (
		@(posedge clk_i) disable iff (!rst_n_i)
		wr.commit |-> wr.wr_en && (wr.wr_addr == sparse_pkg::LD_ADDR_LAST)
	);

endmodule

`default_nettype wire

// ==== hw/sparsemap_pingpong_buf.sv ====
`timescale 1ns/1ps
`default_nettype none

module sparsemap_pingpong_buf (
	input  wire logic                                  clk_i,
	input  wire logic                                  rst_n_i,
	sparsemap_wr_if.buffer                             wr,
	output logic [1:0][sparse_pkg::MEM_SIZE-1:0]       bank_o,
	output logic                                       rd_sel_o,
	output logic                                       map_ready_o
);

	// Both sparsemap banks
	logic [1:0][sparse_pkg::MEM_SIZE-1:0] bank_q;
	// Readable bank
	logic                                 rd_sel_q;
	// Set once any map has been committed
	logic                                 map_ready_q;

	////////////////////////////////////////
	// Bank storage
	////////////////////////////////////////

	// Word k lands at bits LD_WORD_W*k upward
	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			bank_q <= '0;
		end else if (wr.wr_en) begin
			bank_q[wr.wr_bank][sparse_pkg::LD_WORD_W*wr.wr_addr +: sparse_pkg::LD_WORD_W]
				<= wr.wr_data;
		end
	end

	////////////////////////////////////////
	// Read select
	////////////////////////////////////////

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			rd_sel_q    <= 1'b0;
			map_ready_q <= 1'b0;
		end else if (wr.commit) begin
			// Freshly completed bank becomes the readable one
			rd_sel_q    <= wr.wr_bank;
			map_ready_q <= 1'b1;
		end
	end

	assign bank_o      = bank_q;
	assign rd_sel_o    = rd_sel_q;
	assign map_ready_o = map_ready_q;

	// Live map must stay untouched while the loader fills the other bank
	a_no_write_to_rd_bank: assert property (
		@(posedge clk_i) disable iff (!rst_n_i)
		(wr.wr_en && map_ready_q) |-> (wr.wr_bank != rd_sel_q) || wr.commit
	);

endmodule

`default_nettype wire

// ==== hw/sparsemap_wr_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface sparsemap_wr_if;

	// Single-cycle write strobe
	logic                             wr_en;
	// Target bank, always the one not being read once a map is live
	logic                             wr_bank;
	logic [sparse_pkg::LD_ADDR_W-1:0] wr_addr;
	logic [sparse_pkg::LD_WORD_W-1:0] wr_data;
	// Last word of the map, bank becomes readable
	logic                             commit;

	// Producer side
	modport loader (
		output wr_en, wr_bank, wr_addr, wr_data, commit
	);

	// Storage side
	modport buffer (
		input wr_en, wr_bank, wr_addr, wr_data, commit
	);

endinterface

`default_nettype wire

// ==== test/sparse_chunk_vectors.txt ====
# Columns: L word_hex | Q ready a0 a1 a2 a3 chunk0..chunk3_hex count0..count3 | I | E test_name
# Each L, Q or I line is one clock cycle; E closes a test and takes no cycle
Q 0 0 1 2 3 00 00 00 00 0 0 0 0
Q 0 7 7 7 7 00 00 00 00 0 0 0 0
I
E reset_empty
# Map A into bank 0
L 0f01
L 7f03
L ff00
L 55aa
Q 1 0 1 2 3 01 0f 03 7f 1 4 2 7
Q 1 4 5 6 7 00 ff aa 55 0 8 4 4
I
E first_map
Q 1 0 7 3 5 01 55 7f ff 1 4 7 8
Q 1 6 6 6 6 aa aa aa aa 4 4 4 4
Q 1 7 0 7 0 55 01 55 01 4 1 4 1
Q 1 2 2 2 2 03 03 03 03 2 2 2 2
I
E unit_addresses
# Map B into bank 1 while map A stays readable
L c340
Q 1 0 1 2 3 01 0f 03 7f 1 4 2 7
L 3c11
L 00e7
Q 1 4 5 6 7 00 ff aa 55 0 8 4 4
L fe80
Q 1 0 1 2 3 40 c3 11 3c 1 4 2 4
Q 1 4 5 6 7 e7 00 80 fe 6 0 1 7
I
E second_map
# Map C back into bank 0
L 1234
L 5678
Q 1 0 1 2 3 40 c3 11 3c 1 4 2 4
L 9abc
Q 1 7 6 5 4 fe 80 00 e7 7 1 0 6
L def0
Q 1 0 1 2 3 34 12 78 56 3 2 4 4
Q 1 4 5 6 7 bc 9a f0 de 5 4 4 6
I
E third_map
Q 1 7 6 5 4 de f0 9a bc 6 4 4 5
Q 1 3 2 1 0 56 78 12 34 4 4 2 3
Q 1 2 4 6 0 78 bc f0 34 4 5 4 3
Q 1 5 5 1 1 9a 9a 12 12 4 4 2 2
Q 1 0 0 0 0 34 34 34 34 3 3 3 3
I
I
E back_to_back

// ==== test/tb_sparse_chunk.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_sparse_chunk;

	logic                                                                      clk;
	logic                                                                      rst_n;
	logic                                                                      ld_valid;
	logic [sparse_pkg::LD_WORD_W-1:0]                                          ld_data;
	logic                                                                      q_valid;
	logic [sparse_pkg::COMPUTE_UNIT_NUM*sparse_pkg::CHUNK_ADDR_W-1:0]          q_addr;
	logic                                                                      map_ready;
	logic                                                                      count_valid;
	logic [sparse_pkg::COMPUTE_UNIT_NUM*sparse_pkg::PREFIX_SUM_SIZE-1:0]       chunks;
	logic [sparse_pkg::COMPUTE_UNIT_NUM*sparse_pkg::CNT_W-1:0]                 counts;

	// Run bookkeeping
	int error_cnt    = 0;
	int tests_passed = 0;
	int tests_failed = 0;
	int cycle_cnt    = 0;
	// Zero until the vector file has been sized
	int cycle_limit  = 0;

	sparse_chunk_top u_dut (
		.clk_i         (clk),
		.rst_n_i       (rst_n),
		.ld_valid_i    (ld_valid),
		.ld_data_i     (ld_data),
		.q_valid_i     (q_valid),
		.q_addr_i      (q_addr),
		.map_ready_o   (map_ready),
		.count_valid_o (count_valid),
		.chunks_o      (chunks),
		.counts_o      (counts)
	);

	// 40 ns clock
	always #20 clk = ~clk;

	////////////////////////////////////////
	// Timeout watchdog
	////////////////////////////////////////

	always @(posedge clk) begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_limit > 0 && cycle_cnt > cycle_limit) begin
			$display("Run timed out after %0d cycles without reaching the end", cycle_cnt);
			$display("TEST FAIL");
			$finish;
		end
	end

	////////////////////////////////////////
	// Helpers
	////////////////////////////////////////

	// Report a mismatch between expected and observed value
	task automatic compare_value(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			$display("[ERROR] %0d ns: %s mismatch, expected %h, got %h",
				$time, what, expected, actual);
			error_cnt++;
		end
	endtask

	// Reference set-bit count taken one bit at a time
	function automatic int count_set_bits(input logic [7:0] value);
		int total;
		total = 0;
		for (int i = 0; i < 8; i++) begin
			if (value[i]) begin
				total++;
			end
		end
		return total;
	endfunction

	// Number of vector lines for sizing the watchdog
	function automatic int vector_line_total();
		integer         fd;
		integer         code;
		int             lines;
		reg [8*160-1:0] line_buf;
		lines = 0;
		fd = $fopen("test/sparse_chunk_vectors.txt", "r");
		if (fd != 0) begin
			code = 1;
			while (code != 0) begin
				code = $fgets(line_buf, fd);
				if (code != 0) begin
					lines++;
				end
			end
			$fclose(fd);
		end
		return lines;
	endfunction

	// One clock and a check that results follow queries by exactly one cycle
	task automatic advance_cycle(input logic query_sent);
		@(posedge clk);
		#2;
		compare_value("count_valid", {31'd0, query_sent}, {31'd0, count_valid});
		ld_valid = 1'b0;
		q_valid  = 1'b0;
	endtask

	////////////////////////////////////////
	// Vector interpreter
	////////////////////////////////////////

	task automatic run_vectors(input integer fd);
		reg [8*160-1:0] line_buf;
		reg [8*32-1:0]  test_name;
		reg [7:0]       kind;
		integer         code;
		int             fields;
		int             line_no;
		int             err_base;
		int             rdy;
		int             word;
		int             addr [4];
		int             chunk [4];
		int             cnt [4];
		line_no  = 0;
		err_base = error_cnt;
		code     = 1;
		while (code != 0) begin
			line_buf = '0;
			code = $fgets(line_buf, fd);
			if (code != 0) begin
				line_no++;
				fields = $sscanf(line_buf, " %c", kind);
				// Blank and comment lines take no cycle
				if (fields == 1 && kind != "#") begin
					case (kind)
						"L": begin
							fields = $sscanf(line_buf, " %c %h", kind, word);
							ld_valid = 1'b1;
							ld_data  = word[15:0];
							advance_cycle(1'b0);
						end
						"Q": begin
							fields = $sscanf(line_buf,
								" %c %d %d %d %d %d %h %h %h %h %d %d %d %d",
								kind, rdy, addr[0], addr[1], addr[2], addr[3],
								chunk[0], chunk[1], chunk[2], chunk[3],
								cnt[0], cnt[1], cnt[2], cnt[3]);
							if (fields != 14) begin
								$display("Vector line %0d is a malformed query", line_no);
								error_cnt++;
							end
							// Each file count must match its own chunk
							for (int u = 0; u < 4; u++) begin
								if (count_set_bits(chunk[u][7:0]) != cnt[u]) begin
									$display("Vector line %0d: count %0d disagrees with chunk %h",
										line_no, cnt[u], chunk[u][7:0]);
									error_cnt++;
								end
							end
							compare_value("map_ready", rdy, {31'd0, map_ready});
							q_valid = 1'b1;
							for (int u = 0; u < 4; u++) begin
								q_addr[3*u +: 3] = addr[u][2:0];
							end
							advance_cycle(1'b1);
							// Registered results of this query
							for (int u = 0; u < 4; u++) begin
								compare_value($sformatf("unit %0d chunk", u),
									chunk[u][7:0], chunks[8*u +: 8]);
								compare_value($sformatf("unit %0d count", u),
									cnt[u][3:0], counts[4*u +: 4]);
							end
						end
						"I": begin
							advance_cycle(1'b0);
						end
						"E": begin
							fields = $sscanf(line_buf, " %c %s", kind, test_name);
							if (error_cnt == err_base) begin
								tests_passed++;
								$display("test %0s: passed", test_name);
							end else begin
								tests_failed++;
								$display("test %0s: failed with %0d errors",
									test_name, error_cnt - err_base);
							end
							err_base = error_cnt;
						end
						default: begin
							$display("Vector line %0d has an unknown line type", line_no);
							error_cnt++;
						end
					endcase
				end
			end
		end
	endtask

	////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////

	initial begin
		integer fd;
		clk      = 1'b0;
		rst_n    = 1'b0;
		ld_valid = 1'b0;
		ld_data  = '0;
		q_valid  = 1'b0;
		q_addr   = '0;
		cycle_limit = 4 * vector_line_total() + 200;
		fd = $fopen("test/sparse_chunk_vectors.txt", "r");
		// Reset over four rising edges
		repeat (4) @(posedge clk);
		#2;
		rst_n = 1'b1;
		if (fd == 0) begin
			$display("Could not open the vector file test/sparse_chunk_vectors.txt");
			$display("TEST FAIL");
			$finish;
		end else begin
			run_vectors(fd);
			$fclose(fd);
			$display("Summary: %0d tests passed, %0d tests failed, %0d errors",
				tests_passed, tests_failed, error_cnt);
			if (tests_failed == 0 && error_cnt == 0 && tests_passed > 0) begin
				$display("TEST PASS");
			end else begin
				$display("TEST FAIL");
			end
			$finish;
		end
	end

endmodule

`default_nettype wire
